// File: compile.f
+incdir+logic
logic/chip_pkg.sv
logic/uart_link.sv
logic/program_loader.sv
logic/inst_mem.sv
logic/core.sv
logic/chip.sv
verif/tb_clock.sv
verif/chip_tb.sv

// File: logic/chip.sv
`timescale 1ns/1ps
`include "chip_cfg.svh"

module chip (
	input logic clk,
	input logic chip_reset,
	input logic uart_rx,
	output logic uart_tx,
	output chip_pkg::chip_status_t status
);

	import chip_pkg::*;

	localparam int HOLD_BITS = $clog2(`RESET_HOLD + 1);

	logic [HOLD_BITS-1:0] reset_count;
	logic loader_reset, uart_reset, core_reset;
	logic [7:0] rx_data;
	logic rx_valid, rx_lost;
	logic tx_push, tx_credit;
	logic [7:0] tx_data;
	imem_wr_t imem_wr;
	logic [`IMEM_ADDR_BITS-1:0] rd_addr;
	logic [31:0] rd_data;
	logic loaded, halted;

	always_ff @(posedge clk) begin
		if (chip_reset)
			reset_count <= HOLD_BITS'(`RESET_HOLD);
		else if (reset_count != 0)
			reset_count <= reset_count - 1'b1;
	end

	assign loader_reset = (reset_count != 0);
	assign uart_reset = (reset_count != 0);
	assign core_reset = !loaded; // Core runs once the program is in

	assign status = '{
		loading: !loader_reset && !loaded,
		loaded: loaded,
		halted: halted,
		rx_lost: rx_lost
	};

	uart_link uart_i (
		.clk(clk),
		.reset(uart_reset),
		.rx(uart_rx),
		.tx(uart_tx),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.lost(rx_lost),
		.tx_push(tx_push),
		.tx_data(tx_data),
		.tx_credit(tx_credit)
	);

	program_loader loader_i (
		.clk(clk),
		.reset(loader_reset),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.imem_wr(imem_wr),
		.loaded(loaded)
	);

	inst_mem imem_i (
		.clk(clk),
		.wr(imem_wr),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	core core_i (
		.clk(clk),
		.reset(core_reset),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.tx_push(tx_push),
		.tx_data(tx_data),
		.tx_credit(tx_credit),
		.halted(halted)
	);

endmodule

// File: logic/chip_cfg.svh
`ifndef CHIP_CFG_SVH
`define CHIP_CFG_SVH

// Serial line
`define UART_BIT_CYCLES 8

// Transmit FIFO entries, also the core's starting credit count
`define UART_TX_DEPTH 4

// Instruction memory, 64 words
`define IMEM_ADDR_BITS 6

// Loader and UART stay in reset this many cycles after chip_reset
`define RESET_HOLD 15

`endif

// File: logic/chip_pkg.sv
`include "chip_cfg.svh"

package chip_pkg;

	typedef enum logic [3:0] {
		OP_NOP  = 4'd0,
		OP_LI   = 4'd1,
		OP_ADD  = 4'd2,
		OP_SUB  = 4'd3,
		OP_XOR  = 4'd4,
		OP_OUT  = 4'd5,
		OP_HALT = 4'd15
	} opcode_e;

	typedef struct packed {
		opcode_e opcode;
		logic [3:0] rd;
		logic [3:0] rs1;
		logic [3:0] rs2;
		logic [15:0] unused;
	} instr_reg_t;

	typedef struct packed {
		opcode_e opcode;
		logic [3:0] rd;
		logic [7:0] unused;
		logic [15:0] imm;
	} instr_imm_t;

	// Same word, two decodings
	typedef union packed {
		instr_reg_t r;
		instr_imm_t i;
	} instr_u;

	typedef struct packed {
		logic [`IMEM_ADDR_BITS-1:0] addr;
		logic [31:0] data;
		logic valid;
	} imem_wr_t;

	typedef struct packed {
		logic loading;
		logic loaded;
		logic halted;
		logic rx_lost;
	} chip_status_t;

endpackage

// File: logic/core.sv
`timescale 1ns/1ps
`include "chip_cfg.svh"

module core (
	input logic clk,
	input logic reset,
	output logic [`IMEM_ADDR_BITS-1:0] rd_addr,
	input logic [31:0] rd_data,
	output logic tx_push,
	output logic [7:0] tx_data,
	input logic tx_credit,
	output logic halted
);

	import chip_pkg::*;

	localparam int CRED_BITS = $clog2(`UART_TX_DEPTH + 1);
	localparam logic [CRED_BITS-1:0] CRED_INIT = CRED_BITS'(`UART_TX_DEPTH);

	localparam logic [1:0] S_FETCH = 2'd0;
	localparam logic [1:0] S_WAIT = 2'd1;
	localparam logic [1:0] S_EXEC = 2'd2;

	logic [1:0] state;
	logic [`IMEM_ADDR_BITS-1:0] pc;
	logic [15:0] regs [16];
	instr_u ir;
	logic [CRED_BITS-1:0] credits;
	logic exec, is_out, is_halt, out_stall;
	logic wr_en;
	logic [15:0] wr_val;

	assign rd_addr = pc;

	assign exec = (state == S_EXEC) && !halted;
	assign is_out = exec && (ir.r.opcode == OP_OUT);
	assign is_halt = exec && (ir.r.opcode == OP_HALT);
	assign out_stall = is_out && (credits == 0); // Wait for a credit
	assign tx_push = is_out && (credits != 0);
	assign tx_data = regs[ir.r.rd][7:0];

	always_comb begin
		wr_en = 1'b0;
		wr_val = '0;
		if (exec) begin
			case (ir.r.opcode)
				OP_LI: begin
					wr_en = 1'b1;
					wr_val = ir.i.imm;
				end
				OP_ADD: begin
					wr_en = 1'b1;
					wr_val = regs[ir.r.rs1] + regs[ir.r.rs2];
				end
				OP_SUB: begin
					wr_en = 1'b1;
					wr_val = regs[ir.r.rs1] - regs[ir.r.rs2]; // Wraps at 16 bits
				end
				OP_XOR: begin
					wr_en = 1'b1;
					wr_val = regs[ir.r.rs1] ^ regs[ir.r.rs2];
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			regs[ir.r.rd] <= wr_val;
	end

	always_ff @(posedge clk) begin
		if (state == S_WAIT)
			ir <= rd_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_FETCH;
			pc <= '0;
			halted <= 1'b0;
			credits <= CRED_INIT;
		end else begin
			credits <= credits + CRED_BITS'(tx_credit) - CRED_BITS'(tx_push);
			case (state)
				S_FETCH: state <= S_WAIT;
				S_WAIT: state <= S_EXEC;
				default: begin
					if (is_halt)
						halted <= 1'b1; // Stays in EXEC, frozen
					else if (exec && !out_stall) begin
						pc <= pc + 1'b1;
						state <= S_FETCH;
					end
				end
			endcase
		end
	end

	// Credits come back from the UART FIFO, never more than were given
	a_credit_bound: assert property (@(posedge clk) disable iff (reset)
		credits <= CRED_INIT);

endmodule

// File: logic/inst_mem.sv
`timescale 1ns/1ps
`include "chip_cfg.svh"

module inst_mem (
	input logic clk,
	input chip_pkg::imem_wr_t wr,
	input logic [`IMEM_ADDR_BITS-1:0] rd_addr,
	output logic [31:0] rd_data
);

	localparam int DEPTH = 2 ** `IMEM_ADDR_BITS;

	logic [31:0] mem [DEPTH];

	always_ff @(posedge clk) begin
		if (wr.valid)
			mem[wr.addr] <= wr.data;
	end

	// One cycle read latency
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// File: logic/program_loader.sv
`timescale 1ns/1ps
`include "chip_cfg.svh"

module program_loader (
	input logic clk,
	input logic reset,
	input logic [7:0] rx_data,
	input logic rx_valid,
	output chip_pkg::imem_wr_t imem_wr,
	output logic loaded
);

	localparam logic [1:0] LD_COUNT = 2'd0;
	localparam logic [1:0] LD_BYTES = 2'd1;
	localparam logic [1:0] LD_DONE = 2'd2;

	logic [1:0] state;
	logic [7:0] n_words;
	logic [7:0] word_cnt;
	logic [1:0] byte_idx;
	logic [23:0] word_sh; // First three bytes of a word
	logic [`IMEM_ADDR_BITS-1:0] wr_addr;
	logic [31:0] wr_data;
	logic wr_valid;
	logic word_done;

	assign word_done = (state == LD_BYTES) && rx_valid && (byte_idx == 2'd3);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= LD_COUNT;
			word_cnt <= '0;
			byte_idx <= '0;
			wr_valid <= 1'b0;
		end else begin
			wr_valid <= word_done;
			case (state)
				LD_COUNT: begin
					if (rx_valid) begin
						word_cnt <= '0;
						byte_idx <= '0;
						state <= (rx_data == 8'd0) ? LD_DONE : LD_BYTES;
					end
				end
				LD_BYTES: begin
					if (rx_valid) begin
						byte_idx <= byte_idx + 1'b1;
						if (byte_idx == 2'd3) begin
							word_cnt <= word_cnt + 1'b1;
							if (word_cnt == n_words - 1'b1)
								state <= LD_DONE;
						end
					end
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == LD_COUNT && rx_valid)
			n_words <= rx_data;
		if (state == LD_BYTES && rx_valid)
			word_sh <= {rx_data, word_sh[23:8]};
		if (word_done) begin
			wr_data <= {rx_data, word_sh};
			wr_addr <= word_cnt[`IMEM_ADDR_BITS-1:0];
		end
	end

	assign imem_wr = '{addr: wr_addr, data: wr_data, valid: wr_valid};

	// Last write still in flight on the first DONE cycle
	assign loaded = (state == LD_DONE) && !wr_valid;

	a_no_write_after_loaded: assert property (@(posedge clk) disable iff (reset)
		loaded |=> loaded && !imem_wr.valid);

endmodule

// File: logic/uart_link.sv
`timescale 1ns/1ps
`include "chip_cfg.svh"

module uart_link (
	input logic clk,
	input logic reset,
	input logic rx,
	output logic tx,
	output logic [7:0] rx_data,
	output logic rx_valid,
	output logic lost,
	input logic tx_push,
	input logic [7:0] tx_data,
	output logic tx_credit
);

	localparam int CYC_BITS = $clog2(`UART_BIT_CYCLES);
	localparam int PTR_BITS = $clog2(`UART_TX_DEPTH);
	localparam int CNT_BITS = $clog2(`UART_TX_DEPTH + 1);
	localparam logic [CYC_BITS-1:0] BIT_LAST = CYC_BITS'(`UART_BIT_CYCLES - 1);
	localparam logic [CYC_BITS-1:0] HALF_LAST = CYC_BITS'(`UART_BIT_CYCLES / 2 - 1);
	localparam logic [PTR_BITS-1:0] PTR_LAST = PTR_BITS'(`UART_TX_DEPTH - 1);
	localparam logic [CNT_BITS-1:0] FIFO_FULL = CNT_BITS'(`UART_TX_DEPTH);

	localparam logic [1:0] RX_IDLE = 2'd0;
	localparam logic [1:0] RX_START = 2'd1;
	localparam logic [1:0] RX_DATA = 2'd2;
	localparam logic [1:0] RX_STOP = 2'd3;

	logic rx_meta, rx_sync;
	logic [1:0] rx_state;
	logic [CYC_BITS-1:0] rx_cyc;
	logic [2:0] rx_bit;
	logic [7:0] rx_shift;

	logic [7:0] fifo_mem [`UART_TX_DEPTH];
	logic [PTR_BITS-1:0] wr_ptr, rd_ptr;
	logic [CNT_BITS-1:0] fifo_count;
	logic [9:0] tx_shift;
	logic [3:0] tx_bits; // Bits left in the frame
	logic [CYC_BITS-1:0] tx_cyc;
	logic tx_ready, pop;

	always_ff @(posedge clk) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_state <= RX_IDLE;
			rx_cyc <= '0;
			rx_bit <= '0;
			rx_valid <= 1'b0;
			lost <= 1'b0;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_valid <= 1'b0;
			case (rx_state)
				RX_IDLE: begin
					if (!rx_sync) begin
						rx_state <= RX_START;
						rx_cyc <= HALF_LAST;
					end
				end
				RX_START: begin
					if (rx_cyc != 0)
						rx_cyc <= rx_cyc - 1'b1;
					else if (rx_sync)
						rx_state <= RX_IDLE; // Glitch, not a start bit
					else begin
						rx_state <= RX_DATA;
						rx_cyc <= BIT_LAST;
						rx_bit <= '0;
					end
				end
				RX_DATA: begin
					if (rx_cyc != 0)
						rx_cyc <= rx_cyc - 1'b1;
					else begin
						rx_cyc <= BIT_LAST;
						rx_bit <= rx_bit + 1'b1;
						if (rx_bit == 3'd7)
							rx_state <= RX_STOP;
					end
				end
				default: begin
					if (rx_cyc != 0)
						rx_cyc <= rx_cyc - 1'b1;
					else begin
						rx_state <= RX_IDLE;
						if (rx_sync)
							rx_valid <= 1'b1;
						else
							lost <= 1'b1; // Framing error, sticky
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rx_state == RX_DATA && rx_cyc == 0)
			rx_shift <= {rx_sync, rx_shift[7:1]}; // LSB first
	end

	assign rx_data = rx_shift;

	// Load next byte on the last cycle of a stop bit, frames back to back
	assign tx_ready = (tx_bits == 0) || (tx_bits == 4'd1 && tx_cyc == 0);
	assign pop = tx_ready && (fifo_count != 0);
	assign tx_credit = pop;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_count <= '0;
		end else begin
			if (tx_push)
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
			fifo_count <= fifo_count + CNT_BITS'(tx_push) - CNT_BITS'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (tx_push)
			fifo_mem[wr_ptr] <= tx_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			tx_shift <= '1; // Line idles high
			tx_bits <= '0;
			tx_cyc <= '0;
		end else if (pop) begin
			tx_shift <= {1'b1, fifo_mem[rd_ptr], 1'b0};
			tx_bits <= 4'd10;
			tx_cyc <= BIT_LAST;
		end else if (tx_bits != 0) begin
			if (tx_cyc == 0) begin
				tx_shift <= {1'b1, tx_shift[9:1]};
				tx_bits <= tx_bits - 1'b1;
				tx_cyc <= BIT_LAST;
			end else
				tx_cyc <= tx_cyc - 1'b1;
		end
	end

	assign tx = tx_shift[0];

	// Core credit accounting must keep the FIFO from overflowing
	a_no_push_full: assert property (@(posedge clk) disable iff (reset)
		tx_push |-> fifo_count != FIFO_FULL);

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
	--top-module chip_tb -o chip_sim > build.log 2>&1 \
	&& ./obj_dir/chip_sim > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -qx "TEST OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: verif/chip_tb.sv
`timescale 1ns/1ps
`include "chip_cfg.svh"

module chip_tb;

	import chip_pkg::*;

	localparam int BIT = `UART_BIT_CYCLES;
	localparam int PROG_WORDS = 22;
	localparam int OUT_BYTES = 13;
	localparam int WAIT_BITS = 20;
	// Frames take up to 13 bit times with their idle gaps
	localparam int SEND_CYC = (1 + 4 * PROG_WORDS + 2) * 13 * BIT;
	localparam int TIMEOUT = 2 * (SEND_CYC + 3 * PROG_WORDS + 10 * BIT * OUT_BYTES
		+ 2 * (`RESET_HOLD + 8) + 2 * WAIT_BITS * BIT);

	logic clk, chip_reset, uart_rx, uart_tx;
	chip_status_t status;
	logic armed;
	int seed;
	int cycles = 0;
	int idle_breaks = 0;
	int bad_stops = 0;
	int errors, test_errors, tests_run, tests_failed;
	logic [31:0] prog [$];
	logic [7:0] exp_bytes [$];
	logic [7:0] got_bytes [$];
	logic [15:0] model_regs [16];

	tb_clock clock_i (.clk(clk));

	chip chip_i (
		.clk(clk),
		.chip_reset(chip_reset),
		.uart_rx(uart_rx),
		.uart_tx(uart_tx),
		.status(status)
	);

	function automatic logic [31:0] encode_imm(opcode_e op, logic [3:0] rd, logic [15:0] imm);
		instr_u w;
		w.i.opcode = op;
		w.i.rd = rd;
		w.i.unused = '0;
		w.i.imm = imm;
		return w;
	endfunction

	function automatic logic [31:0] encode_reg(opcode_e op, logic [3:0] rd, logic [3:0] rs1,
		logic [3:0] rs2);
		instr_u w;
		w.r.opcode = op;
		w.r.rd = rd;
		w.r.rs1 = rs1;
		w.r.rs2 = rs2;
		w.r.unused = '0;
		return w;
	endfunction

	task report_mismatch(input string name, input logic [31:0] got, input logic [31:0] want);
		errors++;
		test_errors++;
		$display("FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
	endtask

	task report_problem(input string msg);
		errors++;
		test_errors++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	task check_status(input logic [3:0] want);
		@(negedge clk); // Sample away from the active edge
		assert (status == want) else report_mismatch("status", 32'(status), 32'(want));
	endtask

	task finish_test(input string name);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("%-20s %s", name, (test_errors == 0) ? "passed" : "failed");
		test_errors = 0;
	endtask

	task drive_bit(input logic v);
		@(posedge clk);
		#1 uart_rx = v;
		repeat (BIT - 1) @(posedge clk);
	endtask

	task send_frame(input logic [7:0] data, input logic stop);
		int gap;
		gap = $unsigned($random(seed)) % 3;
		if (!stop)
			gap = gap + 2; // Let the receiver settle after a bad frame
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++)
			drive_bit(data[i]);
		drive_bit(stop);
		repeat (gap) drive_bit(1'b1);
	endtask

	task apply_reset;
		armed = 1'b0;
		@(posedge clk);
		#1 chip_reset = 1'b1;
		repeat (4) @(posedge clk);
		#1 chip_reset = 1'b0;
		armed = 1'b1;
		repeat (`RESET_HOLD + 2) @(posedge clk);
	endtask

	task wait_bits(input int n);
		repeat (n * BIT) @(posedge clk);
	endtask

	task build_program;
		prog.delete();
		prog.push_back(encode_imm(OP_LI, 4'd1, 16'h1234));
		prog.push_back(encode_imm(OP_LI, 4'd2, 16'h00f0));
		prog.push_back(encode_reg(OP_ADD, 4'd3, 4'd1, 4'd2));
		prog.push_back(encode_reg(OP_OUT, 4'd3, 4'd0, 4'd0));
		prog.push_back(encode_reg(OP_SUB, 4'd4, 4'd2, 4'd1)); // Wraps below zero
		prog.push_back(encode_reg(OP_OUT, 4'd4, 4'd0, 4'd0));
		prog.push_back(encode_reg(OP_XOR, 4'd5, 4'd1, 4'd2));
		prog.push_back(encode_reg(OP_OUT, 4'd5, 4'd0, 4'd0));
		prog.push_back(encode_imm(OP_LI, 4'd6, 16'($random(seed))));
		prog.push_back(encode_imm(OP_LI, 4'd7, 16'($random(seed))));
		prog.push_back(encode_reg(OP_NOP, 4'd0, 4'd0, 4'd0));
		for (int i = 0; i < 10; i++)
			prog.push_back(encode_reg(OP_OUT, 4'(1 + i % 7), 4'd0, 4'd0)); // Past the credits
		prog.push_back(encode_reg(OP_HALT, 4'd0, 4'd0, 4'd0));
	endtask

	// Reference model of the opcode rules
	task build_expected;
		instr_u ins;
		logic done;
		done = 1'b0;
		exp_bytes.delete();
		foreach (prog[pc]) begin
			ins = prog[pc];
			if (!done) begin
				case (ins.r.opcode)
					OP_LI: model_regs[ins.i.rd] = ins.i.imm;
					OP_ADD: model_regs[ins.r.rd] = model_regs[ins.r.rs1] + model_regs[ins.r.rs2];
					OP_SUB: model_regs[ins.r.rd] = model_regs[ins.r.rs1] - model_regs[ins.r.rs2];
					OP_XOR: model_regs[ins.r.rd] = model_regs[ins.r.rs1] ^ model_regs[ins.r.rs2];
					OP_OUT: exp_bytes.push_back(model_regs[ins.r.rd][7:0]);
					OP_HALT: done = 1'b1;
					default: ;
				endcase
			end
		end
	endtask

	task compare_bytes(input int first, input int last);
		for (int i = first; i <= last; i++)
			assert (got_bytes[i] == exp_bytes[i])
				else report_mismatch($sformatf("uart_tx byte %0d", i), 32'(got_bytes[i]),
					32'(exp_bytes[i]));
	endtask

	always begin : tx_monitor
		logic [7:0] rx_byte;
		@(negedge clk);
		if (armed && uart_tx == 1'b0) begin
			repeat (BIT / 2) @(negedge clk); // Middle of the start bit
			for (int k = 0; k < 8; k++) begin
				repeat (BIT) @(negedge clk);
				rx_byte[k] = uart_tx;
			end
			repeat (BIT) @(negedge clk);
			if (uart_tx != 1'b1)
				bad_stops++;
			got_bytes.push_back(rx_byte);
		end
	end

	always @(negedge clk) begin
		if (armed && !status.loaded && uart_tx != 1'b1)
			idle_breaks++;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT) begin
			$display("Timeout after %0d cycles, the DUT never finished", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		chip_reset = 1'b1;
		uart_rx = 1'b1;
		armed = 1'b0;
		seed = 8184;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;

		apply_reset;
		check_status(4'b1000);
		finish_test("reset state");
		send_frame(8'ha5, 1'b0);
		check_status(4'b1001);
		finish_test("framing error");
		send_frame(8'h00, 1'b1);
		do @(negedge clk); while (!status.loaded);
		wait_bits(WAIT_BITS);
		check_status(4'b0101);
		assert (got_bytes.size() == 0)
			else report_mismatch("uart_tx byte count", 32'(got_bytes.size()), 32'd0);
		finish_test("empty program");

		apply_reset;
		check_status(4'b1000);
		finish_test("reset clears lost");
		build_program;
		build_expected;
		send_frame(8'(prog.size()), 1'b1);
		foreach (prog[w]) begin
			for (int b = 0; b < 4; b++) begin
				check_status(4'b1000);
				send_frame(prog[w][8*b +: 8], 1'b1);
			end
		end
		do @(negedge clk); while (!status.loaded);
		assert (status == 4'b0100) else report_mismatch("status", 32'(status), 32'h4);
		assert (idle_breaks == 0) else report_problem("uart_tx left idle before the load ended");
		finish_test("program load");

		do @(negedge clk); while (got_bytes.size() < exp_bytes.size());
		compare_bytes(0, 2);
		finish_test("arithmetic");
		compare_bytes(3, OUT_BYTES - 1);
		finish_test("out burst");

		do @(negedge clk); while (!status.halted);
		wait_bits(WAIT_BITS);
		check_status(4'b0110);
		assert (got_bytes.size() == exp_bytes.size())
			else report_mismatch("uart_tx byte count", 32'(got_bytes.size()),
				32'(exp_bytes.size()));
		assert (bad_stops == 0) else report_problem("a uart_tx frame ended with a low stop bit");
		finish_test("halt");

		$display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
			tests_run - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #50 clk = ~clk; // 100 ns period

endmodule
